// ==== cache_macros.svh ====
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// ----------------------------------------------------------------------
// Cache geometry
// ----------------------------------------------------------------------

`define CACHE_NUM_SETS 32
`define CACHE_NUM_WAYS 2
`define CACHE_WORDS_PER_LINE 16
`define CACHE_WORD_BITS 32

// Address fields, tag | index | offset | byte
`define CACHE_TAG_LSB 11
`define CACHE_INDEX_LSB 6
`define CACHE_OFFSET_LSB 2

`endif

// ==== cache_pkg.sv ====
`include "cache_macros.svh"

package cache_pkg;

  // ----------------------------------------------------------------------
  // Datapath types
  // ----------------------------------------------------------------------

  typedef logic [`CACHE_WORD_BITS-1:0] word_t;
  typedef logic [`CACHE_WORD_BITS-`CACHE_TAG_LSB-1:0] tag_t;
  typedef logic [`CACHE_TAG_LSB-`CACHE_INDEX_LSB-1:0] index_t;
  typedef logic [`CACHE_INDEX_LSB-`CACHE_OFFSET_LSB-1:0] offset_t;

  typedef logic [`CACHE_WORDS_PER_LINE*`CACHE_WORD_BITS-1:0] line_t;

  // One enable bit per word of a line
  typedef logic [`CACHE_WORDS_PER_LINE-1:0] word_mask_t;

  // Needs one bit more than the offset to hold 16
  typedef logic [$clog2(`CACHE_WORDS_PER_LINE):0] xfer_count_t;

endpackage

// ==== cache_lookup.sv ====
`timescale 1ns/1ps

`include "cache_macros.svh"

module cache_lookup (
  input  logic               clk,
  input  logic               reset,
  input  logic               reg_en_m0,
  input  cache_pkg::word_t   memreq_addr,
  input  cache_pkg::word_t   memreq_data,
  input  logic               tarray_en,
  input  logic               tarray_en2,
  input  logic               tarray_wen,
  input  logic               tarray_wen2,
  input  logic               darray_wen,
  input  logic               darray_wen2,
  input  logic               write_en_sel,
  output cache_pkg::tag_t    req_tag,
  output cache_pkg::index_t  req_index,
  output cache_pkg::offset_t req_offset,
  output cache_pkg::word_t   req_data,
  output cache_pkg::tag_t    victim_tag,
  output logic               hit,
  output logic               way,
  output logic               current_dirty
);

  cache_pkg::tag_t tag_mem0 [`CACHE_NUM_SETS];
  cache_pkg::tag_t tag_mem1 [`CACHE_NUM_SETS];

  logic [`CACHE_NUM_SETS-1:0] valid0;
  logic [`CACHE_NUM_SETS-1:0] valid1;
  logic [`CACHE_NUM_SETS-1:0] dirty0;
  logic [`CACHE_NUM_SETS-1:0] dirty1;
  logic [`CACHE_NUM_SETS-1:0] last_way;

  cache_pkg::tag_t tag0;
  cache_pkg::tag_t tag1;
  logic            hit0;
  logic            hit1;
  logic            word_write;

  // ----------------------------------------------------------------------
  // M0 request registers
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      req_tag    <= '0;
      req_index  <= '0;
      req_offset <= '0;
      req_data   <= '0;
    end else if (reg_en_m0) begin
      req_tag    <= memreq_addr[`CACHE_WORD_BITS-1:`CACHE_TAG_LSB];
      req_index  <= memreq_addr[`CACHE_TAG_LSB-1:`CACHE_INDEX_LSB];
      req_offset <= memreq_addr[`CACHE_INDEX_LSB-1:`CACHE_OFFSET_LSB];
      req_data   <= memreq_data;
    end
  end

  // ----------------------------------------------------------------------
  // Tag compare and way decision
  // ----------------------------------------------------------------------

  assign tag0 = tag_mem0[req_index];
  assign tag1 = tag_mem1[req_index];

  assign hit0 = tarray_en  && valid0[req_index] && (tag0 == req_tag);
  assign hit1 = tarray_en2 && valid1[req_index] && (tag1 == req_tag);

  assign hit = hit0 || hit1;

  // Miss takes the set's last used way
  assign way = hit0 ? 1'b0 : (hit1 ? 1'b1 : last_way[req_index]);

  assign victim_tag    = way ? tag1 : tag0;
  assign current_dirty = way ? dirty1[req_index] : dirty0[req_index];

  // ----------------------------------------------------------------------
  // Tag, valid, dirty and last-way state
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
        tag_mem0[s] <= '0;
        tag_mem1[s] <= '0;
      end
      valid0 <= '0;
      valid1 <= '0;
    end else begin
      if (tarray_wen) begin
        tag_mem0[req_index] <= req_tag;
        valid0[req_index]   <= 1'b1;
      end
      if (tarray_wen2) begin
        tag_mem1[req_index] <= req_tag;
        valid1[req_index]   <= 1'b1;
      end
    end
  end

  // Only a single-word write on a hit marks a line dirty
  assign word_write = write_en_sel && hit && (darray_wen || darray_wen2);

  // A new tag starts the way clean
  always_ff @(posedge clk) begin
    if (reset) begin
      dirty0 <= '0;
      dirty1 <= '0;
    end else begin
      if (tarray_wen) begin
        dirty0[req_index] <= 1'b0;
      end else if (word_write && darray_wen) begin
        dirty0[req_index] <= 1'b1;
      end
      if (tarray_wen2) begin
        dirty1[req_index] <= 1'b0;
      end else if (word_write && !darray_wen) begin
        dirty1[req_index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      last_way <= '0;
    end else begin
      last_way[req_index] <= way;
    end
  end

endmodule

// ==== cache_data_array.sv ====
`timescale 1ns/1ps

`include "cache_macros.svh"

module cache_data_array (
  input  logic                   clk,
  input  logic                   reset,
  input  cache_pkg::index_t      req_index,
  input  cache_pkg::offset_t     req_offset,
  input  cache_pkg::word_t       req_data,
  input  cache_pkg::line_t       refill_line,
  input  logic                   darray_write_sel,
  input  logic                   write_en_sel,
  input  logic                   darray_wen,
  input  logic                   darray_wen2,
  input  logic                   way,
  input  cache_pkg::xfer_count_t spill_count,
  output cache_pkg::word_t       memresp_data,
  output cache_pkg::word_t       spill_word
);

  cache_pkg::line_t data_mem [`CACHE_NUM_WAYS][`CACHE_NUM_SETS];

  cache_pkg::line_t      write_data;
  cache_pkg::word_mask_t word_mask;
  cache_pkg::line_t      sel_line;
  cache_pkg::offset_t    spill_slot;
  logic                  wr_any;
  logic                  wr_way;

  // ----------------------------------------------------------------------
  // Write side
  // ----------------------------------------------------------------------

  // Processor word is copied into every slot, the mask picks the real one
  assign write_data = darray_write_sel ? refill_line
                                       : {`CACHE_WORDS_PER_LINE{req_data}};

  assign word_mask = write_en_sel ? (cache_pkg::word_mask_t'(1) << req_offset) : '1;

  // Way 0 enable has priority
  assign wr_any = darray_wen | darray_wen2;
  assign wr_way = ~darray_wen;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
        for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
          data_mem[w][s] <= '0;
        end
      end
    end else if (wr_any) begin
      for (int k = 0; k < `CACHE_WORDS_PER_LINE; k++) begin
        if (word_mask[k]) begin
          data_mem[wr_way][req_index][k*`CACHE_WORD_BITS +: `CACHE_WORD_BITS] <=
            write_data[k*`CACHE_WORD_BITS +: `CACHE_WORD_BITS];
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Read side
  // ----------------------------------------------------------------------

  assign sel_line = data_mem[way][req_index];

  assign memresp_data = sel_line[req_offset*`CACHE_WORD_BITS +: `CACHE_WORD_BITS];

  // Count of 16 wraps to slot 0, nothing is sent then
  assign spill_slot = cache_pkg::offset_t'(spill_count);
  assign spill_word = sel_line[spill_slot*`CACHE_WORD_BITS +: `CACHE_WORD_BITS];

endmodule

// ==== cache_line_mover.sv ====
`timescale 1ns/1ps

module cache_line_mover (
  input  logic                   clk,
  input  logic                   reset,
  input  cache_pkg::tag_t        req_tag,
  input  cache_pkg::index_t      req_index,
  input  cache_pkg::offset_t     req_offset,
  input  cache_pkg::tag_t        victim_tag,
  input  logic                   z6b_sel,
  input  logic                   spill_or_refill_sel,
  input  logic                   spill_one_word_done,
  input  logic                   refill_one_word_req_sent,
  input  logic                   refill_one_word_resp_received,
  input  cache_pkg::word_t       spill_word,
  input  cache_pkg::word_t       cache_resp_data,
  output cache_pkg::xfer_count_t spill_count,
  output cache_pkg::line_t       refill_line,
  output cache_pkg::word_t       cache_req_addr,
  output cache_pkg::word_t       cache_req_data,
  output logic                   spill_done,
  output logic                   refill_req_done,
  output logic                   refill_resp_done
);

  cache_pkg::xfer_count_t refill_req_count;
  cache_pkg::xfer_count_t refill_resp_count;
  cache_pkg::offset_t     refill_offset;
  cache_pkg::offset_t     resp_slot;
  cache_pkg::word_t       spill_addr;
  cache_pkg::word_t       refill_addr;

  // ----------------------------------------------------------------------
  // Transfer counters
  // ----------------------------------------------------------------------

  assign spill_done       = (spill_count == cache_pkg::xfer_count_t'(16));
  assign refill_req_done  = (refill_req_count == cache_pkg::xfer_count_t'(16));
  assign refill_resp_done = (refill_resp_count == cache_pkg::xfer_count_t'(16));

  always_ff @(posedge clk) begin
    if (reset) begin
      spill_count <= '0;
    end else if (spill_done) begin
      spill_count <= '0;
    end else if (spill_one_word_done) begin
      spill_count <= spill_count + 1'b1;
    end
  end

  // End of the response phase also restarts the request side
  always_ff @(posedge clk) begin
    if (reset) begin
      refill_req_count <= '0;
    end else if (refill_req_done || refill_resp_done) begin
      refill_req_count <= '0;
    end else if (refill_one_word_req_sent) begin
      refill_req_count <= refill_req_count + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      refill_resp_count <= '0;
    end else if (refill_resp_done) begin
      refill_resp_count <= '0;
    end else if (refill_one_word_resp_received) begin
      refill_resp_count <= refill_resp_count + 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Memory request address and data
  // ----------------------------------------------------------------------

  assign spill_addr = {victim_tag, req_index, cache_pkg::offset_t'(0), 2'b00}
                    + (cache_pkg::word_t'(spill_count) << 2);

  // z6b_sel aligns the refill start to the line base
  assign refill_offset = z6b_sel ? cache_pkg::offset_t'(0) : req_offset;
  assign refill_addr   = {req_tag, req_index, refill_offset, 2'b00}
                       + (cache_pkg::word_t'(refill_req_count) << 2);

  assign cache_req_addr = spill_or_refill_sel ? refill_addr : spill_addr;
  assign cache_req_data = spill_word;

  // ----------------------------------------------------------------------
  // Refill line buffer
  // ----------------------------------------------------------------------

  assign resp_slot = cache_pkg::offset_t'(refill_resp_count);

  always_ff @(posedge clk) begin
    if (reset) begin
      refill_line <= '0;
    end else if (refill_one_word_resp_received && !refill_resp_done) begin
      refill_line[resp_slot*$bits(cache_pkg::word_t) +: $bits(cache_pkg::word_t)] <=
        cache_resp_data;
    end
  end

endmodule

// ==== cache_alt_dpath.sv ====
`timescale 1ns/1ps

module cache_alt_dpath (
  input  logic             clk,
  input  logic             reset,

  // Processor side
  input  cache_pkg::word_t memreq_addr,
  input  cache_pkg::word_t memreq_data,
  output cache_pkg::word_t memresp_data,

  // Memory side
  output cache_pkg::word_t cache_req_addr,
  output cache_pkg::word_t cache_req_data,
  input  cache_pkg::word_t cache_resp_data,

  // Controller strobes and selects
  input  logic             reg_en_m0,
  input  logic             tarray_en,
  input  logic             tarray_en2,
  input  logic             tarray_wen,
  input  logic             tarray_wen2,
  input  logic             z6b_sel,
  input  logic             darray_write_sel,
  input  logic             darray_wen,
  input  logic             darray_wen2,
  input  logic             write_en_sel,
  input  logic             spill_one_word_done,
  input  logic             refill_one_word_req_sent,
  input  logic             refill_one_word_resp_received,
  input  logic             spill_or_refill_sel,

  // Status
  output logic             hit,
  output logic             way,
  output logic             current_dirty,
  output logic             spill_done,
  output logic             refill_req_done,
  output logic             refill_resp_done
);

  cache_pkg::tag_t        req_tag;
  cache_pkg::index_t      req_index;
  cache_pkg::offset_t     req_offset;
  cache_pkg::word_t       req_data;
  cache_pkg::tag_t        victim_tag;
  cache_pkg::line_t       refill_line;
  cache_pkg::word_t       spill_word;
  cache_pkg::xfer_count_t spill_count;

  cache_lookup lookup (
    .clk           (clk),
    .reset         (reset),
    .reg_en_m0     (reg_en_m0),
    .memreq_addr   (memreq_addr),
    .memreq_data   (memreq_data),
    .tarray_en     (tarray_en),
    .tarray_en2    (tarray_en2),
    .tarray_wen    (tarray_wen),
    .tarray_wen2   (tarray_wen2),
    .darray_wen    (darray_wen),
    .darray_wen2   (darray_wen2),
    .write_en_sel  (write_en_sel),
    .req_tag       (req_tag),
    .req_index     (req_index),
    .req_offset    (req_offset),
    .req_data      (req_data),
    .victim_tag    (victim_tag),
    .hit           (hit),
    .way           (way),
    .current_dirty (current_dirty)
  );

  cache_data_array data_array (
    .clk              (clk),
    .reset            (reset),
    .req_index        (req_index),
    .req_offset       (req_offset),
    .req_data         (req_data),
    .refill_line      (refill_line),
    .darray_write_sel (darray_write_sel),
    .write_en_sel     (write_en_sel),
    .darray_wen       (darray_wen),
    .darray_wen2      (darray_wen2),
    .way              (way),
    .spill_count      (spill_count),
    .memresp_data     (memresp_data),
    .spill_word       (spill_word)
  );

  cache_line_mover line_mover (
    .clk                           (clk),
    .reset                         (reset),
    .req_tag                       (req_tag),
    .req_index                     (req_index),
    .req_offset                    (req_offset),
    .victim_tag                    (victim_tag),
    .z6b_sel                       (z6b_sel),
    .spill_or_refill_sel           (spill_or_refill_sel),
    .spill_one_word_done           (spill_one_word_done),
    .refill_one_word_req_sent      (refill_one_word_req_sent),
    .refill_one_word_resp_received (refill_one_word_resp_received),
    .spill_word                    (spill_word),
    .cache_resp_data               (cache_resp_data),
    .spill_count                   (spill_count),
    .refill_line                   (refill_line),
    .cache_req_addr                (cache_req_addr),
    .cache_req_data                (cache_req_data),
    .spill_done                    (spill_done),
    .refill_req_done               (refill_req_done),
    .refill_resp_done              (refill_resp_done)
  );

endmodule

// ==== cache_props.sv ====
`timescale 1ns/1ps

module cache_props (
  input logic                   clk,
  input logic                   reset,
  input cache_pkg::xfer_count_t spill_count,
  input cache_pkg::xfer_count_t refill_req_count,
  input cache_pkg::xfer_count_t refill_resp_count,
  input logic                   spill_done,
  input logic                   refill_req_done,
  input logic                   refill_resp_done
);

  localparam cache_pkg::xfer_count_t FULL = 16;

  // Each done level restarts its own counter on the next edge
  spill_done_clears: assert property (@(posedge clk) disable iff (reset)
    spill_done |=> spill_count == '0)
    else $error("spill_count not cleared after spill_done");

  req_done_clears: assert property (@(posedge clk) disable iff (reset)
    refill_req_done |=> refill_req_count == '0)
    else $error("refill request count not cleared after refill_req_done");

  count_limit: assert property (@(posedge clk) disable iff (reset)
    spill_count <= FULL && refill_req_count <= FULL && refill_resp_count <= FULL)
    else $error("transfer counter past a full line");

  // End of the response phase restarts both refill counters
  resp_done_clears: assert property (@(posedge clk) disable iff (reset)
    refill_resp_done |=> refill_req_count == '0 && refill_resp_count == '0)
    else $error("refill counters not cleared after refill_resp_done");

endmodule

bind cache_line_mover cache_props props (
  .clk               (clk),
  .reset             (reset),
  .spill_count       (spill_count),
  .refill_req_count  (refill_req_count),
  .refill_resp_count (refill_resp_count),
  .spill_done        (spill_done),
  .refill_req_done   (refill_req_done),
  .refill_resp_done  (refill_resp_done)
);

// ==== tb_cache.sv ====
`timescale 1ns/1ps

module tb_cache;

  localparam string TEST_FILE = "cache_testdata.txt";
  localparam int CYCLES_PER_LINE = 300;
  localparam int DONE_WAIT = 64;

  logic             clk;
  logic             reset;
  cache_pkg::word_t memreq_addr;
  cache_pkg::word_t memreq_data;
  cache_pkg::word_t memresp_data;
  cache_pkg::word_t cache_req_addr;
  cache_pkg::word_t cache_req_data;
  cache_pkg::word_t cache_resp_data;
  logic             reg_en_m0, tarray_en, tarray_en2, tarray_wen, tarray_wen2;
  logic             z6b_sel, darray_write_sel, darray_wen, darray_wen2, write_en_sel;
  logic             spill_one_word_done, refill_one_word_req_sent;
  logic             refill_one_word_resp_received, spill_or_refill_sel;
  logic             hit, way, current_dirty;
  logic             spill_done, refill_req_done, refill_resp_done;

  int               op_q[$];
  cache_pkg::word_t addr_q[$];
  cache_pkg::word_t data_q[$];
  cache_pkg::word_t exp_q[$];

  // Expected contents of both ways, per set and word
  cache_pkg::word_t shadow [2][32][16];

  int     errors;
  int     checks;
  integer seed;
  int     timeout_cycles;
  bit     loaded;

  cache_alt_dpath dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    wait (loaded);
    repeat (timeout_cycles) @(posedge clk);
    $display("Watchdog timeout, the run did not finish within %0d cycles", timeout_cycles);
    $display("Checks failed");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  task automatic check_value(input string name, input cache_pkg::word_t expected,
                             input cache_pkg::word_t actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("ERR %s expected %h actual %h", name, expected, actual);
    end
  endtask

  function automatic cache_pkg::word_t status_bits();
    return {29'd0, hit, way, current_dirty};
  endfunction

  function automatic cache_pkg::word_t done_bits();
    return {29'd0, spill_done, refill_req_done, refill_resp_done};
  endfunction

  task automatic drive_idle();
    reg_en_m0 = 1'b0;
    tarray_wen = 1'b0;
    tarray_wen2 = 1'b0;
    z6b_sel = 1'b0;
    darray_write_sel = 1'b0;
    darray_wen = 1'b0;
    darray_wen2 = 1'b0;
    write_en_sel = 1'b0;
    spill_one_word_done = 1'b0;
    refill_one_word_req_sent = 1'b0;
    refill_one_word_resp_received = 1'b0;
    spill_or_refill_sel = 1'b0;
  endtask

  task automatic init_inputs();
    reset = 1'b1;
    memreq_addr = '0;
    memreq_data = '0;
    cache_resp_data = '0;
    tarray_en = 1'b0;
    tarray_en2 = 1'b0;
    drive_idle();
  endtask

  task automatic clear_model();
    for (int w = 0; w < 2; w++) begin
      for (int s = 0; s < 32; s++) begin
        for (int k = 0; k < 16; k++) begin
          shadow[w][s][k] = '0;
        end
      end
    end
  endtask

  task automatic load_tests(output bit ok);
    int               fd;
    int               n;
    int               op;
    string            text;
    cache_pkg::word_t a;
    cache_pkg::word_t d;
    cache_pkg::word_t e;
    ok = 1'b0;
    fd = $fopen(TEST_FILE, "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        text = "";
        n = $fgets(text, fd);
        // Skip blank and comment lines
        if (n > 1 && text.getc(0) != "#") begin
          if ($sscanf(text, "%d %h %h %h", op, a, d, e) == 4) begin
            op_q.push_back(op);
            addr_q.push_back(a);
            data_q.push_back(d);
            exp_q.push_back(e);
          end
        end
      end
      $fclose(fd);
      ok = (op_q.size() > 0);
    end
  endtask

  task automatic idle_gap();
    int gap;
    gap = $unsigned($random(seed)) % 3;
    repeat (gap) @(negedge clk);
  endtask

  // Request is captured at the edge between the two falling edges
  task automatic lookup_addr(input cache_pkg::word_t addr, input cache_pkg::word_t data);
    @(negedge clk);
    memreq_addr = addr;
    memreq_data = data;
    reg_en_m0 = 1'b1;
    tarray_en = 1'b1;
    tarray_en2 = 1'b1;
    @(negedge clk);
    reg_en_m0 = 1'b0;
  endtask

  task automatic wait_done(input int sel, input string name);
    int   n;
    logic seen;
    n = 0;
    seen = 1'b0;
    while (!seen && n < DONE_WAIT) begin
      case (sel)
        0: seen = spill_done;
        1: seen = refill_req_done;
        default: seen = refill_resp_done;
      endcase
      if (!seen) begin
        @(negedge clk);
        n++;
      end
    end
    if (!seen) begin
      errors++;
      $display("%s: done level did not rise within %0d cycles", name, DONE_WAIT);
    end
  endtask

  // ----------------------------------------------------------------------
  // Operations
  // ----------------------------------------------------------------------

  task automatic fill_line(input string name, input int w, input cache_pkg::word_t addr,
                           input cache_pkg::word_t data, input cache_pkg::word_t expected);
    cache_pkg::word_t  base;
    cache_pkg::index_t idx;
    base = {addr[31:6], 6'd0};
    idx = addr[10:6];
    lookup_addr(addr, data);
    z6b_sel = 1'b1;
    spill_or_refill_sel = 1'b1;
    @(negedge clk);
    for (int k = 0; k < 16; k++) begin
      idle_gap();
      check_value({name, " refill addr"}, base + cache_pkg::word_t'(4 * k), cache_req_addr);
      check_value({name, " done levels"}, '0, done_bits());
      refill_one_word_req_sent = 1'b1;
      @(negedge clk);
      refill_one_word_req_sent = 1'b0;
    end
    wait_done(1, {name, " refill_req_done"});
    for (int k = 0; k < 16; k++) begin
      idle_gap();
      cache_resp_data = data + cache_pkg::word_t'(4 * k);
      refill_one_word_resp_received = 1'b1;
      @(negedge clk);
      refill_one_word_resp_received = 1'b0;
    end
    wait_done(2, {name, " refill_resp_done"});
    darray_write_sel = 1'b1;
    darray_wen = (w == 0);
    darray_wen2 = (w == 1);
    tarray_wen = (w == 0);
    tarray_wen2 = (w == 1);
    @(negedge clk);
    drive_idle();
    for (int k = 0; k < 16; k++) begin
      shadow[w][idx][k] = data + cache_pkg::word_t'(4 * k);
    end
    check_value({name, " status"}, expected, status_bits());
  endtask

  task automatic write_word(input string name, input cache_pkg::word_t addr,
                            input cache_pkg::word_t data, input cache_pkg::word_t expected);
    int w;
    w = int'(expected[1]);
    lookup_addr(addr, data);
    write_en_sel = 1'b1;
    darray_wen = (w == 0);
    darray_wen2 = (w == 1);
    @(negedge clk);
    drive_idle();
    shadow[w][addr[10:6]][addr[5:2]] = data;
    check_value({name, " status"}, expected, status_bits());
  endtask

  task automatic read_word(input string name, input cache_pkg::word_t addr,
                           input cache_pkg::word_t expected);
    lookup_addr(addr, '0);
    check_value({name, " read"}, expected, memresp_data);
  endtask

  task automatic check_status(input string name, input cache_pkg::word_t addr,
                              input cache_pkg::word_t expected);
    lookup_addr(addr, '0);
    check_value({name, " status"}, expected, status_bits());
    check_value({name, " done levels"}, '0, done_bits());
  endtask

  // Victim way comes in the data column, its line base in the expected column
  task automatic spill_line(input string name, input cache_pkg::word_t addr, input int w,
                            input cache_pkg::word_t base);
    cache_pkg::index_t idx;
    idx = addr[10:6];
    lookup_addr(addr, '0);
    for (int k = 0; k < 16; k++) begin
      idle_gap();
      check_value({name, " spill addr"}, base + cache_pkg::word_t'(4 * k), cache_req_addr);
      check_value({name, " spill data"}, shadow[w][idx][k], cache_req_data);
      spill_one_word_done = 1'b1;
      @(negedge clk);
      spill_one_word_done = 1'b0;
    end
    wait_done(0, {name, " spill_done"});
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    bit    ok;
    string name;
    errors = 0;
    checks = 0;
    seed = 71;
    loaded = 1'b0;
    init_inputs();
    clear_model();
    load_tests(ok);
    if (!ok) begin
      $display("Could not read any test from %s", TEST_FILE);
      $display("Checks failed");
      $finish;
    end else begin
      timeout_cycles = CYCLES_PER_LINE * op_q.size() + 10;
      loaded = 1'b1;
      repeat (10) @(negedge clk);
      reset = 1'b0;
      for (int i = 0; i < op_q.size(); i++) begin
        name = $sformatf("op %0d", i + 1);
        case (op_q[i])
          0: fill_line(name, 0, addr_q[i], data_q[i], exp_q[i]);
          1: fill_line(name, 1, addr_q[i], data_q[i], exp_q[i]);
          2: write_word(name, addr_q[i], data_q[i], exp_q[i]);
          3: read_word(name, addr_q[i], exp_q[i]);
          4: spill_line(name, addr_q[i], int'(data_q[i][0]), exp_q[i]);
          5: check_status(name, addr_q[i], exp_q[i]);
          default: begin
            errors++;
            $display("Unknown operation %0d on test line %0d", op_q[i], i + 1);
          end
        endcase
      end
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
        $display("All checks passed");
      end else begin
        $display("Checks failed");
      end
      $finish;
    end
  end

endmodule

// ==== cache_testdata.txt ====
# op addr data expected, op in decimal and the other columns in hex
# op 0 fill way 0, 1 fill way 1, 2 write word, 3 read, 4 spill, 5 status
# status, fill and write expect {hit, way, dirty}; spill data is the victim way, expected its line base
5 000008c0 00000000 00000000
5 12345678 00000000 00000000
3 000008c4 00000000 00000000
0 000008c8 a0000000 00000004
3 000008c0 00000000 a0000000
3 000008c4 00000000 a0000004
3 000008c8 00000000 a0000008
3 000008cc 00000000 a000000c
3 000008d0 00000000 a0000010
3 000008d4 00000000 a0000014
3 000008d8 00000000 a0000018
3 000008dc 00000000 a000001c
3 000008e0 00000000 a0000020
3 000008e4 00000000 a0000024
3 000008e8 00000000 a0000028
3 000008ec 00000000 a000002c
3 000008f0 00000000 a0000030
3 000008f4 00000000 a0000034
3 000008f8 00000000 a0000038
3 000008fc 00000000 a000003c
2 000008d4 deadbeef 00000005
3 000008d4 00000000 deadbeef
3 000008d0 00000000 a0000010
3 000008d8 00000000 a0000018
5 000008c0 00000000 00000005
1 000010c0 b0000000 00000006
5 000008c0 00000000 00000005
3 000010c0 00000000 b0000000
3 000010fc 00000000 b000003c
5 000028c0 00000000 00000002
5 000008c4 00000000 00000005
5 000028c0 00000000 00000001
4 000028c0 00000000 000008c0
0 001ffc7c 50000000 00000004
3 001ffc7c 00000000 5000003c
2 001ffc60 0badf00d 00000005
3 001ffc60 00000000 0badf00d
3 001ffc5c 00000000 5000001c
5 00000440 00000000 00000001
4 00000440 00000000 001ffc40
3 001ffc64 00000000 50000024

// ==== project.f ====
+incdir+.
cache_pkg.sv
cache_lookup.sv
cache_data_array.sv
cache_line_mover.sv
cache_alt_dpath.sv
cache_props.sv
tb_cache.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cache datapath testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_cache -f project.f -o sim_cache \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_cache | tee /dev/stderr | grep -q "All checks passed" \
  && echo "Simulation PASSED" \
  || { echo "Simulation FAILED"; exit 1; }
